// File: invntt_settings.svh
`ifndef INVNTT_SETTINGS_SVH
`define INVNTT_SETTINGS_SVH

// --------------------
// polynomial geometry
// --------------------
`define INVNTT_N 256
`define INVNTT_W 32
`define INVNTT_LAYERS 8

// --------------------
// modular arithmetic
// --------------------
`define INVNTT_Q 8380417
`define INVNTT_QINV 58728449
// mont^2 / 256, leaves the result in the Montgomery domain
`define INVNTT_F 41978

// fqmul pipeline depth in cycles
`define INVNTT_MUL_LAT 3

`endif

// File: invntt_pkg.sv
`include "invntt_settings.svh"

package invntt_pkg;

    typedef logic signed [`INVNTT_W-1:0] coeff_t;
    typedef logic [$clog2(`INVNTT_N)-1:0] addr_t;
    typedef coeff_t [0:`INVNTT_N-1] coeff_vec_t; // element 0 at the msb end

    typedef struct packed {
        addr_t lo;
        addr_t hi;
        addr_t zeta_idx;
    } bfly_op_t;

    typedef struct packed {
        logic   valid;
        coeff_t a;
        coeff_t b;
        addr_t  addr; // destination of the reduced product
    } mul_req_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
        coeff_t data;
    } wr_req_t;

    // --------------------
    // twiddle table, Montgomery form, walked downward by the inverse transform
    // --------------------
    localparam coeff_t zetas [0:`INVNTT_N-1] = '{
        0, 25847, -2608894, -518909, 237124, -777960, -876248, 466468,
        1826347, 2353451, -359251, -2091905, 3119733, -2884855, 3111497, 2680103,
        2725464, 1024112, -1079900, 3585928, -549488, -1119584, 2619752, -2108549,
        -2118186, -3859737, -1399561, -3277672, 1757237, -19422, 4010497, 280005,
        2706023, 95776, 3077325, 3530437, -1661693, -3592148, -2537516, 3915439,
        -3861115, -3043716, 3574422, -2867647, 3539968, -300467, 2348700, -539299,
        -1699267, -1643818, 3505694, -3821735, 3507263, -2140649, -1600420, 3699596,
        811944, 531354, 954230, 3881043, 3900724, -2556880, 2071892, -2797779,
        -3930395, -1528703, -3677745, -3041255, -1452451, 3475950, 2176455, -1585221,
        -1257611, 1939314, -4083598, -1000202, -3190144, -3157330, -3632928, 126922,
        3412210, -983419, 2147896, 2715295, -2967645, -3693493, -411027, -2477047,
        -671102, -1228525, -22981, -1308169, -381987, 1349076, 1852771, -1430430,
        -3343383, 264944, 508951, 3097992, 44288, -1100098, 904516, 3958618,
        -3724342, -8578, 1653064, -3249728, 2389356, -210977, 759969, -1316856,
        189548, -3553272, 3159746, -1851402, -2409325, -177440, 1315589, 1341330,
        1285669, -1584928, -812732, -1439742, -3019102, -3881060, -3628969, 3839961,
        2091667, 3407706, 2316500, 3817976, -3342478, 2244091, -2446433, -3562462,
        266997, 2434439, -1235728, 3513181, -3520352, -3759364, -1197226, -3193378,
        900702, 1859098, 909542, 819034, 495491, -1613174, -43260, -522500,
        -655327, -3122442, 2031748, 3207046, -3556995, -525098, -768622, -3595838,
        342297, 286988, -2437823, 4108315, 3437287, -3342277, 1735879, 203044,
        2842341, 2691481, -2590150, 1265009, 4055324, 1247620, 2486353, 1595974,
        -3767016, 1250494, 2635921, -3548272, -2994039, 1869119, 1903435, -1050970,
        -1333058, 1237275, -3318210, -1430225, -451100, 1312455, 3306115, -1962642,
        -1279661, 1917081, -2546312, -1374803, 1500165, 777191, 2235880, 3406031,
        -542412, -2831860, -1671176, -1846953, -2584293, -3724270, 594136, -3776993,
        -2013608, 2432395, 2454455, -164721, 1957272, 3369112, 185531, -1207385,
        -3183426, 162844, 1616392, 3014001, 810149, 1652634, -3694233, -1799107,
        -3038916, 3523897, 3866901, 269760, 2213111, -975884, 1717735, 472078,
        -426683, 1723600, -1803090, 1910376, -1667432, -1104333, -260646, -3833893,
        -2939036, -2235985, -420899, -2286327, 183443, -976891, 1612842, -3545687,
        -554416, 3919660, -48306, -1362209, 3937738, 1400424, -846154, 1976782
    };

endpackage

// File: invntt_sequencer.sv
`include "invntt_settings.svh"

module invntt_sequencer
    import invntt_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     rtr,
    input  logic     busy,
    output logic     rd_ready,
    output logic     rd_done,
    output logic     rts,
    output logic     wr_done,
    output logic     load,
    output logic     scale_phase,
    output logic     op_valid,
    output bfly_op_t op,
    output mul_req_t scale_req,
    output addr_t    rd_addr,
    input  coeff_t   rd_data
);
    typedef enum logic [3:0] {
        S_IDLE, S_WAIT, S_READ, S_LAYER_ISSUE, S_LAYER_DRAIN,
        S_SCALE_ISSUE, S_SCALE_DRAIN, S_WRITE, S_DONE
    } state_t;

    localparam addr_t last_len = addr_t'(1 << (`INVNTT_LAYERS - 1));
    localparam addr_t last_bfly = addr_t'(`INVNTT_N / 2 - 1);
    localparam addr_t last_coeff = addr_t'(`INVNTT_N - 1);

    state_t state;
    addr_t  len;
    addr_t  group_start;
    addr_t  offset;
    addr_t  zeta_idx;
    addr_t  cnt; // ops issued in the current phase
    addr_t  lo;

    assign lo = group_start + offset;
    assign op = '{lo: lo, hi: lo + len, zeta_idx: zeta_idx};
    assign op_valid = (state == S_LAYER_ISSUE);
    assign load = (state == S_READ);
    assign scale_phase = (state == S_SCALE_ISSUE) || (state == S_SCALE_DRAIN);
    assign rd_addr = cnt;
    assign scale_req = '{valid: (state == S_SCALE_ISSUE), a: rd_data,
                         b: coeff_t'(`INVNTT_F), addr: cnt};

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            rd_ready <= 1'b0;
            rd_done <= 1'b0;
            rts <= 1'b0;
            wr_done <= 1'b0;
            len <= addr_t'(1);
            group_start <= '0;
            offset <= '0;
            zeta_idx <= last_coeff;
            cnt <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    rd_ready <= 1'b0;
                    rd_done <= 1'b0;
                    rts <= 1'b0;
                    wr_done <= 1'b0;
                    len <= addr_t'(1);
                    group_start <= '0;
                    offset <= '0;
                    zeta_idx <= last_coeff; // twiddles walk down from the top
                    cnt <= '0;
                    state <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (rtr)
                    begin
                        rd_ready <= 1'b1;
                        state <= S_READ;
                    end
                end
                S_READ:
                begin
                    rd_ready <= 1'b0;
                    rd_done <= 1'b1; // store captures inp on this edge
                    state <= S_LAYER_ISSUE;
                end
                // --------------------
                // butterfly layers
                // --------------------
                S_LAYER_ISSUE:
                begin
                    cnt <= cnt + 1'b1;
                    if (offset == len - 1'b1)
                    begin
                        offset <= '0;
                        group_start <= group_start + (len << 1);
                        zeta_idx <= zeta_idx - 1'b1; // one twiddle per group
                    end
                    else
                        offset <= offset + 1'b1;
                    if (cnt == last_bfly)
                        state <= S_LAYER_DRAIN;
                end
                S_LAYER_DRAIN:
                begin
                    if (!busy)
                    begin
                        cnt <= '0;
                        offset <= '0;
                        group_start <= '0;
                        if (len == last_len)
                            state <= S_SCALE_ISSUE;
                        else
                        begin
                            len <= len << 1;
                            state <= S_LAYER_ISSUE;
                        end
                    end
                end
                // --------------------
                // final scaling
                // --------------------
                S_SCALE_ISSUE:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == last_coeff)
                        state <= S_SCALE_DRAIN;
                end
                S_SCALE_DRAIN:
                begin
                    if (!busy)
                        state <= S_WRITE;
                end
                S_WRITE:
                begin
                    rts <= 1'b1;
                    wr_done <= 1'b1;
                    state <= S_DONE;
                end
                S_DONE:
                begin
                    rts <= 1'b0;
                    state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: coeff_store.sv
`include "invntt_settings.svh"

module coeff_store
    import invntt_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       load,
    input  coeff_vec_t load_data,
    input  addr_t      rd_addr_a,
    input  addr_t      rd_addr_b,
    input  addr_t      rd_addr_c,
    input  wr_req_t    sum_wr,
    input  wr_req_t    prod_wr,
    output coeff_t     rd_data_a,
    output coeff_t     rd_data_b,
    output coeff_t     rd_data_c,
    output coeff_vec_t all_data
);
    coeff_t mem [`INVNTT_N];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `INVNTT_N; i++)
                mem[i] <= '0;
        end
        else if (load)
        begin
            for (int i = 0; i < `INVNTT_N; i++)
                mem[i] <= load_data[i]; // wide parallel load
        end
        else
        begin
            if (sum_wr.valid)
                mem[sum_wr.addr] <= sum_wr.data;
            if (prod_wr.valid)
                mem[prod_wr.addr] <= prod_wr.data; // distinct from sum_wr within a layer
        end
    end

    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];
    assign rd_data_c = mem[rd_addr_c]; // scaling reads

    always_comb
    begin
        for (int i = 0; i < `INVNTT_N; i++)
            all_data[i] = mem[i];
    end

endmodule

// File: butterfly_stage.sv
module butterfly_stage
    import invntt_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     op_valid,
    input  bfly_op_t op,
    input  coeff_t   lo_data,
    input  coeff_t   hi_data,
    output addr_t    rd_addr_lo,
    output addr_t    rd_addr_hi,
    output wr_req_t  sum_wr,
    output mul_req_t mul_req,
    output logic     busy
);
    coeff_t zeta_neg;
    coeff_t sum;
    coeff_t diff;

    // --------------------
    // combinational read and arithmetic
    // --------------------
    assign rd_addr_lo = op.lo;
    assign rd_addr_hi = op.hi;

    assign zeta_neg = -zetas[op.zeta_idx]; // inverse uses the negated twiddle
    assign sum = lo_data + hi_data;
    assign diff = lo_data - hi_data;

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            sum_wr.valid <= 1'b0;
            mul_req.valid <= 1'b0;
        end
        else
        begin
            sum_wr.valid <= op_valid;
            mul_req.valid <= op_valid;
        end
        sum_wr.addr <= op.lo; // sum goes straight back
        sum_wr.data <= sum;
        mul_req.a <= zeta_neg;
        mul_req.b <= diff;
        mul_req.addr <= op.hi; // product lands on the hi slot
    end

    assign busy = sum_wr.valid;

endmodule

// File: fqmul_pipe.sv
`include "invntt_settings.svh"

module fqmul_pipe
    import invntt_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  mul_req_t req,
    output wr_req_t  wr,
    output logic     busy
);
    localparam int dw = 2 * `INVNTT_W;
    localparam logic signed [dw-1:0] q_wide = `INVNTT_Q;

    logic [`INVNTT_MUL_LAT-1:0] valid_q;
    addr_t                      addr_q [`INVNTT_MUL_LAT];
    logic signed [dw-1:0]       prod_s1;
    logic signed [dw-1:0]       prod_s2;
    coeff_t                     t_s2;
    logic signed [dw-1:0]       reduced;
    coeff_t                     res_s3;

    // valid and address ride along with the data
    always_ff @(posedge clock)
    begin
        if (reset)
            valid_q <= '0;
        else
            valid_q <= {valid_q[`INVNTT_MUL_LAT-2:0], req.valid};
        addr_q[0] <= req.addr;
        for (int i = 1; i < `INVNTT_MUL_LAT; i++)
            addr_q[i] <= addr_q[i-1];
    end

    // --------------------
    // Montgomery reduction
    // --------------------
    assign reduced = prod_s2 - t_s2 * q_wide; // low word cancels to zero

    always_ff @(posedge clock)
    begin
        prod_s1 <= $signed(req.a) * $signed(req.b); // full signed product
        prod_s2 <= prod_s1;
        t_s2 <= prod_s1[`INVNTT_W-1:0] * `INVNTT_QINV; // low 32 bits only
        res_s3 <= reduced[dw-1:`INVNTT_W];
    end

    assign wr = '{valid: valid_q[`INVNTT_MUL_LAT-1],
                  addr: addr_q[`INVNTT_MUL_LAT-1],
                  data: res_s3};

    assign busy = |valid_q;

endmodule

// File: invntt_top.sv
module invntt_top
    import invntt_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       rtr,
    input  coeff_vec_t inp,
    output logic       rd_ready,
    output logic       rd_done,
    output logic       rts,
    output logic       wr_done,
    output coeff_vec_t out
);
    logic       load;
    logic       scale_phase;
    logic       op_valid;
    bfly_op_t   op;
    mul_req_t   scale_req;
    addr_t      scale_addr;
    coeff_t     scale_data;
    addr_t      addr_lo;
    addr_t      addr_hi;
    coeff_t     lo_data;
    coeff_t     hi_data;
    wr_req_t    sum_wr;
    wr_req_t    prod_wr;
    mul_req_t   bfly_mul_req;
    mul_req_t   mul_req;
    logic       bfly_busy;
    logic       mul_busy;
    logic       busy;
    coeff_vec_t all_data;
    coeff_vec_t out_q;

    invntt_sequencer u_seq (
        .clock(clock), .reset(reset), .rtr(rtr), .busy(busy),
        .rd_ready(rd_ready), .rd_done(rd_done), .rts(rts), .wr_done(wr_done),
        .load(load), .scale_phase(scale_phase), .op_valid(op_valid), .op(op),
        .scale_req(scale_req), .rd_addr(scale_addr), .rd_data(scale_data)
    );

    coeff_store u_store (
        .clock(clock), .reset(reset), .load(load), .load_data(inp),
        .rd_addr_a(addr_lo), .rd_addr_b(addr_hi), .rd_addr_c(scale_addr),
        .sum_wr(sum_wr), .prod_wr(prod_wr),
        .rd_data_a(lo_data), .rd_data_b(hi_data), .rd_data_c(scale_data),
        .all_data(all_data)
    );

    butterfly_stage u_bfly (
        .clock(clock), .reset(reset), .op_valid(op_valid), .op(op),
        .lo_data(lo_data), .hi_data(hi_data), .rd_addr_lo(addr_lo), .rd_addr_hi(addr_hi),
        .sum_wr(sum_wr), .mul_req(bfly_mul_req), .busy(bfly_busy)
    );

    assign mul_req = scale_phase ? scale_req : bfly_mul_req; // scaling bypasses the butterfly

    fqmul_pipe u_mul (
        .clock(clock), .reset(reset), .req(mul_req), .wr(prod_wr), .busy(mul_busy)
    );

    assign busy = bfly_busy | mul_busy;

    always_ff @(posedge clock)
    begin
        if (rts)
            out_q <= all_data;
    end

    // valid with rts, held while wr_done, zero otherwise
    assign out = wr_done ? (rts ? all_data : out_q) : '0;

endmodule

// File: invntt_assertions.sv
module invntt_assertions
    import invntt_pkg::*;
(
    input logic    clock,
    input logic    reset,
    input logic    rd_ready,
    input logic    rd_done,
    input logic    rts,
    input wr_req_t sum_wr,
    input wr_req_t prod_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0; // failed assertions so far

    // --------------------
    // strobes
    // --------------------
    rd_ready_pulse: assert property (@(posedge clock) disable iff (reset) rd_ready |=> !rd_ready)
        else
        begin
            failures++;
            $error("rd_ready stayed high for more than one cycle");
        end

    rts_pulse: assert property (@(posedge clock) disable iff (reset) rts |=> !rts)
        else
        begin
            failures++;
            $error("rts stayed high for more than one cycle");
        end

    rts_after_read: assert property (@(posedge clock) disable iff (reset) rts |-> rd_done)
        else
        begin
            failures++;
            $error("rts rose while rd_done was low");
        end

    // --------------------
    // write ports
    // --------------------
    no_write_collision: assert property (@(posedge clock) disable iff (reset)
        (sum_wr.valid && prod_wr.valid) |-> (sum_wr.addr != prod_wr.addr))
        else
        begin
            failures++;
            $error("sum and product writes hit the same address");
        end

endmodule

// File: invntt_tb.sv
`include "invntt_settings.svh"

module invntt_tb
    import invntt_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout = 5000; // cycles per wait

    typedef enum {kind_zero, kind_impulse, kind_const, kind_random} kind_t;
    typedef enum {on_rd_ready, on_rts, on_idle} wait_t;
    typedef struct {
        string name;
        kind_t kind;
        int    param;
    } vector_case_t;

    // --------------------
    // stimulus table
    // --------------------
    vector_case_t cases [6] = '{
        '{"all_zero", kind_zero, 0},
        '{"impulse_0", kind_impulse, 0},
        '{"impulse_131", kind_impulse, 131},
        '{"const_half_q", kind_const, 4190208},
        '{"random_a", kind_random, 0},
        '{"random_b", kind_random, 0}
    };

    logic       clock;
    logic       reset;
    logic       rtr;
    coeff_vec_t inp;
    logic       rd_ready;
    logic       rd_done;
    logic       rts;
    logic       wr_done;
    coeff_vec_t out;
    integer     seed;

    invntt_top dut (
        .clock(clock), .reset(reset), .rtr(rtr), .inp(inp), .rd_ready(rd_ready),
        .rd_done(rd_done), .rts(rts), .wr_done(wr_done), .out(out)
    );

    bind invntt_top invntt_assertions u_assert (
        .clock(clock), .reset(reset), .rd_ready(rd_ready), .rd_done(rd_done),
        .rts(rts), .sum_wr(sum_wr), .prod_wr(prod_wr)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic coeff_t mont_reduce(longint a);
        int t;
        t = int'(a * longint'(`INVNTT_QINV)); // low word only
        return coeff_t'((a - longint'(t) * longint'(`INVNTT_Q)) >>> 32);
    endfunction

    function automatic coeff_vec_t ref_invntt(coeff_vec_t v);
        coeff_t     a [`INVNTT_N];
        coeff_t     t;
        coeff_t     d;
        coeff_t     zeta;
        int         k;
        coeff_vec_t r;
        for (int i = 0; i < `INVNTT_N; i++)
            a[i] = v[i];
        k = `INVNTT_N;
        for (int len = 1; len < `INVNTT_N; len = len * 2)
        begin
            for (int start = 0; start < `INVNTT_N; start = start + 2 * len)
            begin
                k = k - 1;
                zeta = -zetas[k];
                for (int j = start; j < start + len; j++)
                begin
                    t = a[j];
                    a[j] = t + a[j + len];
                    d = t - a[j + len]; // wraps at 32 bits
                    a[j + len] = mont_reduce(longint'(zeta) * longint'(d));
                end
            end
        end
        for (int i = 0; i < `INVNTT_N; i++)
            r[i] = mont_reduce(longint'(a[i]) * longint'(`INVNTT_F));
        return r;
    endfunction

    task automatic make_vector(input vector_case_t c, output coeff_vec_t v);
        v = '0;
        for (int i = 0; i < `INVNTT_N; i++)
        begin
            case (c.kind)
                kind_impulse: v[i] = (i == c.param) ? coeff_t'(`INVNTT_Q - 1) : '0;
                kind_const: v[i] = c.param;
                kind_random: v[i] = $random(seed) % (`INVNTT_Q + 1); // -Q..Q
                default: v[i] = '0;
            endcase
        end
    endtask

    // --------------------
    // checks and waits
    // --------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_coeffs(input string name, input coeff_vec_t expected,
                                input coeff_vec_t actual);
        int first;
        first = -1;
        for (int i = `INVNTT_N - 1; i >= 0; i--)
            if (actual[i] !== expected[i])
                first = i;
        if (first >= 0)
            report_failure($sformatf("error: %s coefficient %0d expected %0d actual %0d",
                                     name, first, expected[first], actual[first]));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            report_failure($sformatf("error: %s expected %b actual %b", name, expected, actual));
    endtask

    // bound assertions fire on the rising edge
    always @(negedge clock)
    begin
        if (dut.u_assert.failures != 0)
            report_failure("an assertion inside the DUT failed");
    end

    function automatic logic reached(wait_t w);
        case (w)
            on_rd_ready: return rd_ready;
            on_rts: return rts;
            default: return !rd_done; // back in idle
        endcase
    endfunction

    task automatic wait_for(input string name, input wait_t w);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clock);
            cycles++;
        end
        while (reached(w) !== 1'b1 && cycles < timeout);
        if (reached(w) !== 1'b1)
            report_failure($sformatf("%s: timed out waiting for %s", name, w.name()));
    endtask

    task automatic run_case(input vector_case_t c);
        coeff_vec_t stim;
        coeff_vec_t expected;
        make_vector(c, stim);
        expected = ref_invntt(stim);
        @(posedge clock);
        inp <= stim;
        rtr <= 1'b1;
        wait_for(c.name, on_rd_ready);
        @(posedge clock);
        rtr <= 1'b0; // inp captured on this edge
        @(negedge clock);
        check_flag({c.name, "_rd_done"}, 1'b1, rd_done);
        wait_for(c.name, on_rts);
        check_coeffs(c.name, expected, out);
        check_flag({c.name, "_wr_done"}, 1'b1, wr_done);
        @(negedge clock);
        check_flag({c.name, "_rts_pulse"}, 1'b0, rts);
        check_coeffs({c.name, "_hold"}, expected, out);
        wait_for(c.name, on_idle);
        check_flag({c.name, "_wr_done_clear"}, 1'b0, wr_done);
        check_coeffs({c.name, "_out_clear"}, '0, out);
    endtask

    initial
    begin
        seed = 49;
        reset = 1'b1;
        rtr = 1'b0;
        inp = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("reset_rd_ready", 1'b0, rd_ready);
        check_flag("reset_rd_done", 1'b0, rd_done);
        check_flag("reset_rts", 1'b0, rts);
        check_flag("reset_wr_done", 1'b0, wr_done);
        check_coeffs("reset_out", '0, out);
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clock);
            check_flag("rtr_low_rd_ready", 1'b0, rd_ready);
        end
        foreach (cases[i])
            run_case(cases[i]);
        if (dut.u_assert.failures == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            report_failure("an assertion inside the DUT failed");
    end

endmodule

// File: invntt.f
+incdir+.
invntt_pkg.sv
invntt_sequencer.sv
coeff_store.sv
butterfly_stage.sv
fqmul_pipe.sv
invntt_top.sv
invntt_assertions.sv
invntt_tb.sv
